// File: rtl/xm_pkg.sv
// shared types for the host register block of the video controller
// compile first, modules pick it up by import
`default_nettype none

package xm_pkg;

    typedef logic [7:0]  byte_t;                // host bus byte
    typedef logic [15:0] word_t;                // register and vram word
    typedef logic [15:0] addr_t;                // vram word address

    localparam int INTR_BITS = 4;               // interrupt sources
    typedef logic [INTR_BITS-1:0] intr_t;

    localparam logic [3:0] WRMASK_RESET = 4'b1111;  // all nibbles written

    // host visible register numbers, others read zero
    typedef enum logic [3:0] {
        SYS_CTRL = 4'h0,                        // busy, write mask
        INT_CTRL = 4'h1,                        // intr mask / clear
        TIMER    = 4'h2,                        // tenth ms timer
        RD_INCR  = 4'h3,                        // read address step
        RD_ADDR  = 4'h4,                        // read address, odd byte starts read
        WR_INCR  = 4'h5,                        // write address step
        WR_ADDR  = 4'h6,                        // write address
        DATA     = 4'h7,                        // vram data window
        DATA_2   = 4'h8                         // alias of DATA
    } xm_reg_e;

    // one host byte access, strobes last a single cycle
    typedef struct packed {
        logic    wr;                            // write strobe
        logic    rd;                            // read strobe
        xm_reg_e reg_num;                       // register number
        logic    bytesel;                       // 0 = even (high) byte
        byte_t   data;                          // write data
    } host_bus_t;

    // vram request, held until ack
    typedef struct packed {
        logic       sel;                        // request active
        logic       wr;                         // 1 = write
        logic [3:0] wrmask;                     // nibble write enables
        addr_t      addr;
        word_t      data;                       // write data
    } vram_req_t;

    // register file settings used by the vram port
    typedef struct packed {
        word_t      rd_incr;
        word_t      wr_incr;
        logic [3:0] wrmask;
    } vram_cfg_t;

    // vram port state for host readback
    typedef struct packed {
        logic  busy;                            // access or increment pending
        addr_t rd_addr;
        addr_t wr_addr;
        word_t rd_data;                         // prefetched word
    } vram_view_t;

    typedef enum logic [1:0] {
        IDLE,
        READ,
        WRITE
    } vram_state_e;

endpackage

`default_nettype wire

// File: rtl/xm_reg_file.sv
// host register file: increments, write mask, interrupt control, timer latch
// and the byte readback mux; vram addresses and data come from the vram port
`default_nettype none

module xm_reg_file (
    input  wire logic               clk,
    input  wire logic               reset_i,
    input  wire xm_pkg::host_bus_t  bus_i,          // host strobes and data
    input  wire xm_pkg::word_t      timer_i,        // live timer count
    input  wire xm_pkg::vram_view_t vram_view_i,    // vram port readback
    input  wire xm_pkg::intr_t      intr_status_i,  // pending interrupts
    output      xm_pkg::byte_t      bus_data_o,     // read data, valid while rd
    output      xm_pkg::vram_cfg_t  vram_cfg_o,     // incr and mask to vram port
    output      xm_pkg::intr_t      intr_mask_o,    // enabled interrupts
    output      xm_pkg::intr_t      intr_clear_o    // one cycle clear pulse
);
    import xm_pkg::*;

    vram_cfg_t  cfg_q;                  // rd/wr incr and nibble mask
    intr_t      intr_mask_q;
    byte_t      timer_lo_q;             // low byte held for a coherent pair
    word_t      rd_word;                // selected register before byte pick
    logic       timer_hi_rd;            // even byte read of TIMER

    assign vram_cfg_o  = cfg_q;
    assign intr_mask_o = intr_mask_q;

    assign timer_hi_rd = bus_i.rd && !bus_i.bytesel && (bus_i.reg_num == TIMER);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            cfg_q.rd_incr <= '0;
            cfg_q.wr_incr <= '0;
            cfg_q.wrmask  <= WRMASK_RESET;
            intr_mask_q   <= '0;
            intr_clear_o  <= '0;
            timer_lo_q    <= '0;
        end else begin
            intr_clear_o <= '0;                     // strobe, one cycle only

            if (bus_i.wr) begin
                case (bus_i.reg_num)
                    SYS_CTRL: begin
                        if (bus_i.bytesel) begin
                            cfg_q.wrmask <= bus_i.data[3:0];   // odd byte holds mask
                        end
                    end
                    INT_CTRL: begin
                        if (!bus_i.bytesel) begin
                            intr_mask_q  <= bus_i.data[INTR_BITS-1:0];
                        end else begin
                            intr_clear_o <= bus_i.data[INTR_BITS-1:0];  // ack pending
                        end
                    end
                    RD_INCR: begin
                        if (!bus_i.bytesel) begin
                            cfg_q.rd_incr[15:8] <= bus_i.data;
                        end else begin
                            cfg_q.rd_incr[7:0]  <= bus_i.data;
                        end
                    end
                    WR_INCR: begin
                        if (!bus_i.bytesel) begin
                            cfg_q.wr_incr[15:8] <= bus_i.data;
                        end else begin
                            cfg_q.wr_incr[7:0]  <= bus_i.data;
                        end
                    end
                    default: begin
                        // vram registers live in the vram port
                    end
                endcase
            end

            if (timer_hi_rd) begin
                timer_lo_q <= timer_i[7:0];         // low byte frozen for next read
            end
        end
    end

    // readback word per register
    always_comb begin
        case (bus_i.reg_num)
            SYS_CTRL: rd_word = {vram_view_i.busy, 11'b0, cfg_q.wrmask};
            INT_CTRL: rd_word = {byte_t'(intr_mask_q), byte_t'(intr_status_i)};
            TIMER:    rd_word = {timer_i[15:8], timer_lo_q};   // live high, latched low
            RD_INCR:  rd_word = cfg_q.rd_incr;
            RD_ADDR:  rd_word = vram_view_i.rd_addr;
            WR_INCR:  rd_word = cfg_q.wr_incr;
            WR_ADDR:  rd_word = vram_view_i.wr_addr;
            DATA,
            DATA_2:   rd_word = vram_view_i.rd_data;            // prefetched word
            default:  rd_word = '0;
        endcase
    end

    // even byte is the high half
    always_comb begin
        if (bus_i.rd) begin
            bus_data_o = bus_i.bytesel ? rd_word[7:0] : rd_word[15:8];
        end else begin
            bus_data_o = '0;
        end
    end

    // clear is a single pulse even under back to back writes
    a_clear_one_cycle: assert property (
        @(posedge clk) disable iff (reset_i)
        (intr_clear_o != '0) |=> (intr_clear_o == '0)
    ) else $error("intr_clear_o held for more than one cycle");

endmodule

`default_nettype wire

// File: rtl/vram_port.sv
// vram window: read/write address registers, access FSM with prefetch
// and the post-access address increment, two edges after the ack edge
`default_nettype none

module vram_port (
    input  wire logic               clk,
    input  wire logic               reset_i,
    input  wire xm_pkg::host_bus_t  bus_i,          // host strobes and data
    input  wire xm_pkg::vram_cfg_t  vram_cfg_i,     // incr and mask settings
    input  wire logic               vram_ack_i,     // access done this cycle
    input  wire xm_pkg::word_t      vram_data_i,    // read data, valid with ack
    output      xm_pkg::vram_req_t  vram_o,         // registered request
    output      xm_pkg::vram_view_t vram_view_o     // readback and busy
);
    import xm_pkg::*;

    vram_state_e state;
    vram_req_t   req_q;
    addr_t       rd_addr;
    addr_t       wr_addr;
    byte_t       data_even;             // high byte waiting for odd write
    word_t       rd_data;               // prefetched word
    word_t       incr_sum;              // next address, registered adder
    logic        incr_pend;             // set on the ack edge
    logic        incr_apply;            // sum ready, load on next edge
    logic        incr_rd;               // 1 = step rd_addr, 0 = wr_addr
    logic        busy;

    logic        is_data;               // DATA or DATA_2 selected
    logic        trig_rd_addr;          // odd write of RD_ADDR
    logic        trig_wr_data;          // odd write of data register
    logic        trig_prefetch;         // odd read of data register
    logic        trigger;

    assign is_data       = (bus_i.reg_num == DATA) || (bus_i.reg_num == DATA_2);
    assign trig_rd_addr  = bus_i.wr && bus_i.bytesel && (bus_i.reg_num == RD_ADDR);
    assign trig_wr_data  = bus_i.wr && bus_i.bytesel && is_data;
    assign trig_prefetch = bus_i.rd && bus_i.bytesel && is_data;
    assign trigger       = trig_rd_addr || trig_wr_data || trig_prefetch;

    assign busy = (state != IDLE) || incr_pend || incr_apply;   // through the increment

    assign vram_o      = req_q;
    assign vram_view_o = '{busy: busy, rd_addr: rd_addr, wr_addr: wr_addr, rd_data: rd_data};

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state      <= IDLE;
            req_q.sel  <= 1'b0;
            req_q.wr   <= 1'b0;
            rd_addr    <= '0;
            wr_addr    <= '0;
            incr_pend  <= 1'b0;
            incr_apply <= 1'b0;
            incr_rd    <= 1'b0;
        end else begin
            incr_pend  <= 1'b0;
            incr_apply <= incr_pend;

            // access done, drop request and queue the increment
            if (vram_ack_i && state != IDLE) begin
                req_q.sel <= 1'b0;
                req_q.wr  <= 1'b0;
                state     <= IDLE;
                incr_pend <= 1'b1;
                incr_rd   <= (state == READ);
                if (state == READ) begin
                    rd_data <= vram_data_i;         // becomes DATA readback
                end
            end

            if (incr_pend) begin
                incr_sum <= incr_rd ? rd_addr + vram_cfg_i.rd_incr
                                    : wr_addr + vram_cfg_i.wr_incr;
            end

            if (incr_apply) begin
                if (incr_rd) begin
                    rd_addr <= incr_sum;
                end else begin
                    wr_addr <= incr_sum;
                end
            end

            // host address and data writes
            if (bus_i.wr) begin
                case (bus_i.reg_num)
                    RD_ADDR: begin
                        if (!bus_i.bytesel) begin
                            rd_addr[15:8] <= bus_i.data;
                        end else begin
                            rd_addr[7:0]  <= bus_i.data;
                        end
                    end
                    WR_ADDR: begin
                        if (!bus_i.bytesel) begin
                            wr_addr[15:8] <= bus_i.data;
                        end else begin
                            wr_addr[7:0]  <= bus_i.data;
                        end
                    end
                    DATA,
                    DATA_2: begin
                        if (!bus_i.bytesel) begin
                            data_even <= bus_i.data;    // wait for low half
                        end
                    end
                    default: begin
                    end
                endcase
            end

            if (trig_rd_addr || trig_prefetch) begin
                req_q.sel    <= 1'b1;
                req_q.wr     <= 1'b0;
                req_q.wrmask <= vram_cfg_i.wrmask;
                req_q.data   <= '0;
                // new address goes out directly on an RD_ADDR write
                req_q.addr   <= trig_rd_addr ? {rd_addr[15:8], bus_i.data} : rd_addr;
                state        <= READ;
            end

            if (trig_wr_data) begin
                req_q.sel    <= 1'b1;
                req_q.wr     <= 1'b1;
                req_q.wrmask <= vram_cfg_i.wrmask;
                req_q.addr   <= wr_addr;
                req_q.data   <= {data_even, bus_i.data};
                state        <= WRITE;
            end
        end
    end

    // host has to poll busy before starting another access
    a_no_trigger_busy: assert property (
        @(posedge clk) disable iff (reset_i)
        trigger |-> !busy
    ) else $error("vram access started while busy");

    // request held steady until the memory side acks
    a_req_stable: assert property (
        @(posedge clk) disable iff (reset_i)
        (vram_o.sel && !vram_ack_i) |=> (vram_o.sel && $stable(vram_o))
    ) else $error("vram request changed before ack");

    a_no_idle_ack: assert property (
        @(posedge clk) disable iff (reset_i)
        vram_ack_i |-> (state != IDLE)
    ) else $error("vram ack with no access outstanding");

endmodule

`default_nettype wire

// File: rtl/tenth_ms_timer.sv
// free running tick counter at TICK_HZ from a CLK_HZ clock
// fractional divider so the clock need not be a multiple of the tick rate
`default_nettype none

module tenth_ms_timer #(
    parameter int CLK_HZ  = 25_000_000,     // input clock rate
    parameter int TICK_HZ = 10_000          // counter rate
) (
    input  wire logic           clk,
    input  wire logic           reset_i,
    output      xm_pkg::word_t  timer_o     // tick count that wraps at 16 bits
);
    import xm_pkg::*;

    // signed accumulator wide enough for -(CLK_HZ - TICK_HZ)
    localparam int ACC_BITS = $clog2(CLK_HZ) + 1;
    localparam logic [ACC_BITS-1:0] STEP_UP   = ACC_BITS'(TICK_HZ);
    localparam logic [ACC_BITS-1:0] STEP_TICK = ACC_BITS'(TICK_HZ - CLK_HZ);

    logic [ACC_BITS-1:0] acc;
    word_t               count;
    logic                tick;

    assign tick    = !acc[ACC_BITS-1];      // non-negative means a tick is due
    assign timer_o = count;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            acc   <= '0;
            count <= '0;
        end else begin
            if (tick) begin
                acc   <= acc + STEP_TICK;   // pay back one whole tick
                count <= count + 1'b1;
            end else begin
                acc   <= acc + STEP_UP;
            end
        end
    end

    // accumulator stays between TICK_HZ - CLK_HZ and just below TICK_HZ
    a_acc_range: assert property (
        @(posedge clk) disable iff (reset_i)
        ($signed(acc) >= TICK_HZ - CLK_HZ) && ($signed(acc) < TICK_HZ)
    ) else $error("timer accumulator out of range");

endmodule

`default_nettype wire

// File: rtl/xm_regs_top.sv
// top of the host register block: register file, vram port and timer
// clock rates set here and handed to the timer
`default_nettype none

module xm_regs_top #(
    parameter int CLK_HZ  = 25_000_000,     // system clock rate
    parameter int TICK_HZ = 10_000          // timer rate, tenth ms
) (
    input  wire logic               clk,
    input  wire logic               reset_i,
    input  wire xm_pkg::host_bus_t  bus_i,          // host byte access
    output      xm_pkg::byte_t      bus_data_o,     // host read data
    output      xm_pkg::vram_req_t  vram_o,         // vram request
    input  wire logic               vram_ack_i,
    input  wire xm_pkg::word_t      vram_data_i,
    input  wire xm_pkg::intr_t      intr_status_i,
    output      xm_pkg::intr_t      intr_mask_o,
    output      xm_pkg::intr_t      intr_clear_o
);
    import xm_pkg::*;

    word_t      timer;                  // live tick count
    vram_cfg_t  vram_cfg;               // register file to vram port
    vram_view_t vram_view;              // vram port back for readback

    xm_reg_file u_reg_file (
        .clk            (clk),
        .reset_i        (reset_i),
        .bus_i          (bus_i),
        .timer_i        (timer),
        .vram_view_i    (vram_view),
        .intr_status_i  (intr_status_i),
        .bus_data_o     (bus_data_o),
        .vram_cfg_o     (vram_cfg),
        .intr_mask_o    (intr_mask_o),
        .intr_clear_o   (intr_clear_o)
    );

    vram_port u_vram_port (
        .clk            (clk),
        .reset_i        (reset_i),
        .bus_i          (bus_i),
        .vram_cfg_i     (vram_cfg),
        .vram_ack_i     (vram_ack_i),
        .vram_data_i    (vram_data_i),
        .vram_o         (vram_o),
        .vram_view_o    (vram_view)
    );

    tenth_ms_timer #(
        .CLK_HZ         (CLK_HZ),
        .TICK_HZ        (TICK_HZ)
    ) u_timer (
        .clk            (clk),
        .reset_i        (reset_i),
        .timer_o        (timer)
    );

endmodule

`default_nettype wire

// File: sim/xm_regs_checks.svh
// reference model of the register block and the typed compare tasks
// included inside the testbench module, reads its mirror variables
`ifndef XM_REGS_CHECKS_SVH
`define XM_REGS_CHECKS_SVH

// vram word after a masked write, one enable per nibble
function automatic word_t masked_word(word_t old_w, word_t new_w, logic [3:0] mask);
    word_t w;
    w = old_w;
    for (int n = 0; n < 4; n++) begin
        if (mask[n]) begin
            w[n*4 +: 4] = new_w[n*4 +: 4];      // nibble n enabled
        end
    end
    return w;
endfunction

// expected host read byte, timer is checked by its difference instead
function automatic byte_t ref_read(xm_reg_e num, logic bytesel);
    word_t w;
    case (num)
        SYS_CTRL: w = {1'b0, 11'b0, ref_wrmask};    // read only when idle
        INT_CTRL: w = {byte_t'(ref_intr_mask), byte_t'(intr_status)};
        RD_INCR:  w = ref_rd_incr;
        RD_ADDR:  w = ref_rd_addr;
        WR_INCR:  w = ref_wr_incr;
        WR_ADDR:  w = ref_wr_addr;
        DATA,
        DATA_2:   w = ref_rd_data;                  // word already fetched
        default:  w = '0;
    endcase
    return bytesel ? w[7:0] : w[15:8];              // even byte is high half
endfunction

// expected request for one trigger
function automatic vram_req_t ref_request(logic wr, addr_t addr, word_t data);
    vram_req_t r;
    r.sel    = 1'b1;
    r.wr     = wr;
    r.wrmask = ref_wrmask;
    r.addr   = addr;
    r.data   = data;
    return r;
endfunction

task automatic check_byte(string name, byte_t exp_b, byte_t got);
    if (got !== exp_b) begin
        $display("Fail %s: expected %h, got %h", name, exp_b, got);
        stop_run();
    end
endtask

// data and mask only matter on writes
task automatic check_req(vram_req_t exp_r, vram_req_t got);
    logic bad;
    bad = (got.sel !== exp_r.sel) || (got.wr !== exp_r.wr) || (got.addr !== exp_r.addr);
    if (exp_r.wr) begin
        bad = bad || (got.data !== exp_r.data) || (got.wrmask !== exp_r.wrmask);
    end
    if (bad) begin
        $display("Fail vram_o: expected %h, got %h", exp_r, got);
        stop_run();
    end
endtask

task automatic check_intr(string name, intr_t exp_i, intr_t got);
    if (got !== exp_i) begin
        $display("Fail %s: expected %h, got %h", name, exp_i, got);
        stop_run();
    end
endtask

task automatic check_word(string name, word_t exp_w, word_t got);
    if (got !== exp_w) begin
        $display("Fail %s: expected %h, got %h", name, exp_w, got);
        stop_run();
    end
endtask

`endif

// File: sim/tb_xm_regs.sv
// testbench for the host register block with host byte sequences, a vram model
// with random ack latency and checks against a reference model
`default_nettype none

module tb_xm_regs;
    import xm_pkg::*;

    localparam int CLK_HZ          = 100_000;           // one tick every 10 cycles
    localparam int TICK_HZ         = 10_000;
    localparam int CYCLES_PER_TICK = CLK_HZ / TICK_HZ;
    localparam int N_WR            = 8;                 // words per write burst
    localparam int N_RD            = 8;                 // reads in prefetch chain
    localparam int N_OPS           = 50 + 3 * N_WR + 5 * N_RD;  // fixed sections plus bursts
    localparam int WATCHDOG_CYCLES = N_OPS * 200 + 2000;

    logic       clk;
    logic       reset;
    host_bus_t  bus;
    byte_t      bus_data;
    vram_req_t  vram_req;
    logic       vram_ack;
    word_t      vram_data;
    intr_t      intr_status;
    intr_t      intr_mask;
    intr_t      intr_clear;

    word_t      vram_mem [0:65535];     // vram model contents
    word_t      ref_mem  [0:65535];     // expected contents
    vram_req_t  exp_req_q [$];          // one entry per trigger
    word_t      ref_rd_incr;
    word_t      ref_wr_incr;
    logic [3:0] ref_wrmask;
    addr_t      ref_rd_addr;
    addr_t      ref_wr_addr;
    word_t      ref_rd_data;
    intr_t      ref_intr_mask;
    int         cycle;

    xm_regs_top #(
        .CLK_HZ         (CLK_HZ),
        .TICK_HZ        (TICK_HZ)
    ) UUT (
        .clk            (clk),
        .reset_i        (reset),
        .bus_i          (bus),
        .bus_data_o     (bus_data),
        .vram_o         (vram_req),
        .vram_ack_i     (vram_ack),
        .vram_data_i    (vram_data),
        .intr_status_i  (intr_status),
        .intr_mask_o    (intr_mask),
        .intr_clear_o   (intr_clear)
    );

    task automatic stop_run();
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    `include "xm_regs_checks.svh"

    function automatic word_t fill_pattern(addr_t a);
        return (a * 16'h9e37) ^ 16'hc3a5;   // every address bit matters
    endfunction

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    // one strobe cycle driven 5 after the edge
    task automatic host_write(xm_reg_e num, logic bytesel, byte_t data);
        @(posedge clk);
        #5;
        bus         = '0;
        bus.wr      = 1'b1;
        bus.reg_num = num;
        bus.bytesel = bytesel;
        bus.data    = data;
        @(posedge clk);
        #5;
        bus = '0;
    endtask

    task automatic host_read(xm_reg_e num, logic bytesel, output byte_t val);
        @(posedge clk);
        #5;
        bus         = '0;
        bus.rd      = 1'b1;
        bus.reg_num = num;
        bus.bytesel = bytesel;
        #20;
        val = bus_data;                     // sampled mid cycle
        @(posedge clk);
        #5;
        bus = '0;
    endtask

    task automatic expect_read(xm_reg_e num, logic bytesel);
        byte_t exp_b;
        byte_t got;
        exp_b = ref_read(num, bytesel);     // before any prefetch it starts
        host_read(num, bytesel, got);
        check_byte($sformatf("bus_data_o (%s byte %0d)", num.name(), bytesel), exp_b, got);
    endtask

    // poll busy in SYS_CTRL bit 15
    task automatic wait_idle();
        byte_t b;
        int    polls;
        polls = 0;
        do begin
            host_read(SYS_CTRL, 1'b0, b);
            polls++;
            if (polls > 50) begin
                $display("busy still set after 50 polls of SYS_CTRL");
                stop_run();
            end
        end while (b[7]);
    endtask

    // vram model that acks 1 to 4 cycles after sel rises
    initial begin : vram_model
        vram_req_t r;
        int        lat;
        vram_ack  = 1'b0;
        vram_data = '0;
        forever begin
            @(posedge clk);
            #1;
            if (vram_req.sel === 1'b1) begin
                r = vram_req;
                if (exp_req_q.size() == 0) begin
                    $display("vram request seen with no access expected");
                    stop_run();
                end
                check_req(exp_req_q.pop_front(), r);
                lat = $urandom_range(4, 1);
                repeat (lat) @(posedge clk);
                #5;
                vram_ack = 1'b1;
                if (r.wr) begin
                    vram_mem[r.addr] = masked_word(vram_mem[r.addr], r.data, r.wrmask);
                end else begin
                    vram_data = vram_mem[r.addr];
                end
                @(posedge clk);
                #5;
                vram_ack = 1'b0;
            end
        end
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, run did not finish", WATCHDOG_CYCLES);
        $display("ERRORS FOUND");
        $fatal(1);
    end

    initial begin : main
        xm_reg_e reset_regs [6] = '{SYS_CTRL, INT_CTRL, RD_INCR, RD_ADDR, WR_INCR, WR_ADDR};
        word_t   start;
        word_t   w;
        word_t   t0;
        word_t   t1;
        byte_t   b;
        intr_t   bits;
        int      c0;
        int      c1;
        int      ticks;
        int      moved;

        void'($urandom(32'hb21c));
        bus         = '0;
        intr_status = '0;
        reset       = 1'b1;
        for (int a = 0; a < 65536; a++) begin
            vram_mem[a] = fill_pattern(addr_t'(a));
            ref_mem[a]  = fill_pattern(addr_t'(a));
        end
        ref_rd_incr   = '0;
        ref_wr_incr   = '0;
        ref_wrmask    = WRMASK_RESET;
        ref_rd_addr   = '0;
        ref_wr_addr   = '0;
        ref_rd_data   = '0;
        ref_intr_mask = '0;
        repeat (3) @(posedge clk);
        #5;
        reset = 1'b0;

        // reset values
        check_intr("intr_mask_o", '0, intr_mask);
        check_intr("intr_clear_o", '0, intr_clear);
        if (vram_req.sel !== 1'b0) begin
            $display("Fail vram_o.sel: expected 0, got %h", vram_req.sel);
            stop_run();
        end
        for (int i = 0; i < 6; i++) begin
            expect_read(reset_regs[i], 1'b0);
            expect_read(reset_regs[i], 1'b1);
        end

        // masked write burst with increment
        ref_wr_incr = word_t'($urandom());
        ref_wrmask  = 4'($urandom());
        start       = word_t'($urandom());
        host_write(WR_INCR, 1'b0, ref_wr_incr[15:8]);
        host_write(WR_INCR, 1'b1, ref_wr_incr[7:0]);
        host_write(SYS_CTRL, 1'b1, byte_t'(ref_wrmask));
        host_write(WR_ADDR, 1'b0, start[15:8]);
        host_write(WR_ADDR, 1'b1, start[7:0]);
        ref_wr_addr = start;
        expect_read(SYS_CTRL, 1'b1);
        for (int i = 0; i < N_WR; i++) begin
            w = word_t'($urandom());
            wait_idle();
            host_write((i % 2) ? DATA_2 : DATA, 1'b0, w[15:8]);
            exp_req_q.push_back(ref_request(1'b1, ref_wr_addr, w));
            host_write((i % 2) ? DATA_2 : DATA, 1'b1, w[7:0]);     // starts the write
            ref_mem[ref_wr_addr] = masked_word(ref_mem[ref_wr_addr], w, ref_wrmask);
            ref_wr_addr = ref_wr_addr + ref_wr_incr;
        end
        wait_idle();
        expect_read(WR_ADDR, 1'b0);
        expect_read(WR_ADDR, 1'b1);
        for (int a = 0; a < 65536; a++) begin
            if (vram_mem[a] !== ref_mem[a]) begin
                check_word($sformatf("vram word %h", a), ref_mem[a], vram_mem[a]);
            end
        end

        // read prefetch chain
        ref_rd_incr = word_t'($urandom());
        start       = word_t'($urandom());
        host_write(RD_INCR, 1'b0, ref_rd_incr[15:8]);
        host_write(RD_INCR, 1'b1, ref_rd_incr[7:0]);
        host_write(RD_ADDR, 1'b0, start[15:8]);
        exp_req_q.push_back(ref_request(1'b0, start, '0));
        host_write(RD_ADDR, 1'b1, start[7:0]);
        wait_idle();
        ref_rd_data = ref_mem[start];
        ref_rd_addr = start + ref_rd_incr;
        expect_read(RD_ADDR, 1'b0);
        expect_read(RD_ADDR, 1'b1);
        for (int i = 0; i < N_RD; i++) begin
            expect_read(DATA, 1'b0);
            exp_req_q.push_back(ref_request(1'b0, ref_rd_addr, '0));
            expect_read((i % 2) ? DATA_2 : DATA, 1'b1);             // launches next read
            wait_idle();
            ref_rd_data = ref_mem[ref_rd_addr];
            ref_rd_addr = ref_rd_addr + ref_rd_incr;
            expect_read(RD_ADDR, 1'b0);
            expect_read(RD_ADDR, 1'b1);
        end

        // interrupt mask, clear pulse and status readback
        for (int i = 0; i < 4; i++) begin
            bits = intr_t'($urandom());
            host_write(INT_CTRL, 1'b0, byte_t'(bits));
            ref_intr_mask = bits;
            check_intr("intr_mask_o", ref_intr_mask, intr_mask);
            bits = intr_t'($urandom_range(15, 1));
            host_write(INT_CTRL, 1'b1, byte_t'(bits));
            check_intr("intr_clear_o", bits, intr_clear);           // pulse cycle
            @(posedge clk);
            #5;
            check_intr("intr_clear_o", '0, intr_clear);
            intr_status = intr_t'($urandom());
            expect_read(INT_CTRL, 1'b0);
            expect_read(INT_CTRL, 1'b1);
        end

        // timer pair read twice across a random wait
        host_read(TIMER, 1'b0, b);
        c0 = cycle;
        t0[15:8] = b;
        host_read(TIMER, 1'b1, b);
        t0[7:0] = b;
        repeat ($urandom_range(400, 40)) @(posedge clk);
        host_read(TIMER, 1'b0, b);
        c1 = cycle;
        t1[15:8] = b;
        host_read(TIMER, 1'b1, b);
        t1[7:0] = b;
        ticks = (c1 - c0) / CYCLES_PER_TICK;
        moved = int'(t1) - int'(t0);
        if (moved < ticks - 1 || moved > ticks + 1) begin
            $display("Fail timer_o delta: expected %h plus or minus 1, got %h",
                     ticks, moved);
            stop_run();
        end

        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb.f
+incdir+sim
rtl/xm_pkg.sv
rtl/xm_reg_file.sv
rtl/vram_port.sv
rtl/tenth_ms_timer.sv
rtl/xm_regs_top.sv
sim/tb_xm_regs.sv
